// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = fragmentPipelineTb
FILELIST  = files.f
OBJ_DIR   = obj_dir
PASS_MSG  = TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/blendUnit.sv
/*
 * blender
 * weights source and frame buffer colors by alpha based factors and sums them
 */
`timescale 1ns/1ps
`include "fragmentParams.svh"

module blendUnit
    import fragmentPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  blendFactorT srcFactor,
    input  blendFactorT dstFactor,
    input  colorT       srcColor,
    input  colorT       dstColor,
    input  logic        inValid,
    output colorT       blendColor,
    output logic        outValid
);

    localparam int CHANNELS = $bits(colorT) / `CHANNEL_WIDTH;

    channelT srcAlpha;
    channelT dstAlpha;
    channelT srcWeight;
    channelT dstWeight;
    productT srcProd [CHANNELS];
    productT dstProd [CHANNELS];
    logic    prodValid;

    // all factors are alpha based, so one weight serves every channel
    function automatic channelT selectFactor(blendFactorT code, channelT as, channelT ad);
        case (code)
            `BLEND_ONE:                 return `CHANNEL_MAX;
            `BLEND_SRC_ALPHA:           return as;
            `BLEND_ONE_MINUS_SRC_ALPHA: return `CHANNEL_MAX - as;
            `BLEND_DST_ALPHA:           return ad;
            `BLEND_ONE_MINUS_DST_ALPHA: return `CHANNEL_MAX - ad;
            default:                    return '0;
        endcase
    endfunction

    assign srcAlpha  = srcColor[0 +: `CHANNEL_WIDTH];
    assign dstAlpha  = dstColor[0 +: `CHANNEL_WIDTH];
    assign srcWeight = selectFactor(srcFactor, srcAlpha, dstAlpha);
    assign dstWeight = selectFactor(dstFactor, srcAlpha, dstAlpha);

    ////////////////////////////////////////////////////////////
    // stage one, weighted products
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        for (int c = 0; c < CHANNELS; c++)
        begin
            srcProd[c] <= productT'(srcWeight)
                        * productT'(srcColor[c*`CHANNEL_WIDTH +: `CHANNEL_WIDTH]);
            dstProd[c] <= productT'(dstWeight)
                        * productT'(dstColor[c*`CHANNEL_WIDTH +: `CHANNEL_WIDTH]);
        end
    end

    ////////////////////////////////////////////////////////////
    // stage two, sum and saturate
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        for (int c = 0; c < CHANNELS; c++)
            blendColor[c*`CHANNEL_WIDTH +: `CHANNEL_WIDTH] <= saturateSum(srcProd[c], dstProd[c]);
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            prodValid <= 1'b0;
            outValid  <= 1'b0;
        end
        else
        begin
            prodValid <= inValid;
            outValid  <= prodValid;
        end
    end

endmodule

// File: design/compareFunc.sv
/*
 * compare function
 * evaluates one of the eight depth/alpha test functions
 */
`timescale 1ns/1ps
`include "fragmentParams.svh"

module compareFunc
    import fragmentPkg::*;
#(
    parameter int VALUE_WIDTH = 16
)
(
    input  cmpFuncT                func,
    input  logic [VALUE_WIDTH-1:0] value,
    input  logic [VALUE_WIDTH-1:0] reference,
    output logic                   passed
);

    logic less;
    logic equal;
    logic greater;

    assign less    = value < reference;
    assign equal   = value == reference;
    assign greater = value > reference;

    always_comb
    begin
        case (func)
            `CMP_NEVER:    passed = 1'b0;
            `CMP_LESS:     passed = less;
            `CMP_EQUAL:    passed = equal;
            `CMP_LEQUAL:   passed = less | equal;
            `CMP_GREATER:  passed = greater;
            `CMP_NOTEQUAL: passed = !equal;
            `CMP_GEQUAL:   passed = greater | equal;
            default:       passed = 1'b1;
        endcase
    end

endmodule

// File: design/confRegs.sv
/*
 * configuration registers
 * wishbone classic slave holding the test and shading setup words
 */
`timescale 1ns/1ps
`include "fragmentParams.svh"

module confRegs
    import fragmentPkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wbCyc,
    input  logic                        wbStb,
    input  logic                        wbWe,
    input  logic [`CONF_ADDR_WIDTH-1:0] wbAdr,
    input  confWordT                    wbDatW,
    output logic                        wbAck,
    output confWordT                    wbDatR,
    output confWordT                    testConf,
    output confWordT                    shadeConf
);

    // texenv disable, source one, destination zero
    localparam confWordT SHADE_RESET =
        confWordT'({`BLEND_ZERO, 1'b0, `BLEND_ONE, 2'b00, `TEX_ENV_DISABLE});

    logic access;

    // one access per strobe, the ack itself closes the window
    assign access = wbCyc && wbStb && !wbAck;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wbAck     <= 1'b0;
            testConf  <= '0;
            shadeConf <= SHADE_RESET;
        end
        else
        begin
            wbAck <= access;
            if (access && wbWe)
            begin
                if (wbAdr == '0)
                    testConf <= wbDatW;
                else
                    shadeConf <= wbDatW;
            end
        end
    end

    // readback
    always_ff @(posedge clk)
    begin
        if (access && !wbWe)
            wbDatR <= (wbAdr == '0) ? testConf : shadeConf;
    end

endmodule

// File: design/fragmentParams.svh
/*
 * fragment pipeline parameters
 * data widths, configuration register fields and function codes
 */
`ifndef FRAGMENT_PARAMS_SVH
`define FRAGMENT_PARAMS_SVH

// data widths
`define FB_INDEX_WIDTH     14
`define DEPTH_WIDTH        16
`define CHANNEL_WIDTH      4
`define CONF_ADDR_WIDTH    1
`define CONF_DATA_WIDTH    16
`define CHANNEL_MAX        4'd15

// function code widths
`define CMP_FUNC_WIDTH     3
`define TEX_ENV_WIDTH      2
`define BLEND_FACTOR_WIDTH 3

// register 0, test setup
`define REG0_DEPTH_FUNC_LSB  0
`define REG0_DEPTH_ENABLE    3
`define REG0_ALPHA_FUNC_LSB  4
`define REG0_ALPHA_REF_LSB   8

// register 1, shading setup
`define REG1_TEX_ENV_LSB     0
`define REG1_SRC_FACTOR_LSB  4
`define REG1_DST_FACTOR_LSB  8

// compare functions
`define CMP_ALWAYS   3'd0
`define CMP_NEVER    3'd1
`define CMP_LESS     3'd2
`define CMP_EQUAL    3'd3
`define CMP_LEQUAL   3'd4
`define CMP_GREATER  3'd5
`define CMP_NOTEQUAL 3'd6
`define CMP_GEQUAL   3'd7

// texture environment modes
`define TEX_ENV_DISABLE  2'd0
`define TEX_ENV_REPLACE  2'd1
`define TEX_ENV_MODULATE 2'd2
`define TEX_ENV_DECAL    2'd3

// blend factors, codes 6 and 7 behave as zero
`define BLEND_ZERO                3'd0
`define BLEND_ONE                 3'd1
`define BLEND_SRC_ALPHA           3'd2
`define BLEND_ONE_MINUS_SRC_ALPHA 3'd3
`define BLEND_DST_ALPHA           3'd4
`define BLEND_ONE_MINUS_DST_ALPHA 3'd5

`endif

// File: design/fragmentPipeline.sv
/*
 * fragment pipeline top
 * frame buffer read, texture environment, depth and alpha tests,
 * blending and write back, one fragment per clock
 */
`timescale 1ns/1ps
`include "fragmentParams.svh"

module fragmentPipeline
    import fragmentPkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wbCyc,
    input  logic                        wbStb,
    input  logic                        wbWe,
    input  logic [`CONF_ADDR_WIDTH-1:0] wbAdr,
    input  confWordT                    wbDatW,
    output logic                        wbAck,
    output confWordT                    wbDatR,
    input  logic                        fragValid,
    input  fbIndexT                     fragIndex,
    input  depthT                       fragDepth,
    input  colorT                       fragColor,
    input  colorT                       fragTexel,
    output fbIndexT                     colorIndexRead,
    output fbIndexT                     depthIndexRead,
    input  colorT                       colorIn,
    input  depthT                       depthIn,
    output fbIndexT                     colorIndexWrite,
    output fbIndexT                     depthIndexWrite,
    output logic                        colorWriteEnable,
    output logic                        depthWriteEnable,
    output colorT                       colorOut,
    output depthT                       depthOut,
    output logic                        fragBusy
);

    confWordT    testConf;
    confWordT    shadeConf;
    cmpFuncT     depthFunc;
    cmpFuncT     alphaFunc;
    logic        depthEnable;
    channelT     alphaRef;
    texEnvFuncT  texEnvMode;
    blendFactorT srcFactor;
    blendFactorT dstFactor;

    logic    s0Valid;
    fbIndexT s0Index;
    depthT   s0Depth;
    colorT   s0TriColor;
    colorT   s0Texel;
    logic    s1Valid;
    depthT   s1Depth;
    colorT   s1TriColor;
    colorT   s1Texel;
    fbIndexT s2Index;
    depthT   s2Depth;
    depthT   s2DepthIn;
    colorT   s2DstColor;
    fbIndexT s3Index;
    depthT   s3Depth;
    logic    s3DepthOk;
    colorT   s3DstColor;
    fbIndexT s4Index;
    depthT   s4Depth;
    logic    s4Write;
    fbIndexT s5Index;
    depthT   s5Depth;
    logic    s5Write;

    colorT      texColor;
    logic       texValid;
    colorT      blendColor;
    logic       blendValid;
    logic       depthPass;
    logic       alphaPass;
    logic [2:0] inFlight;

    confRegs u_confRegs (
        .clk       (clk),
        .rst       (rst),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAdr     (wbAdr),
        .wbDatW    (wbDatW),
        .wbAck     (wbAck),
        .wbDatR    (wbDatR),
        .testConf  (testConf),
        .shadeConf (shadeConf)
    );

    // register field decode
    assign depthFunc   = testConf[`REG0_DEPTH_FUNC_LSB +: `CMP_FUNC_WIDTH];
    assign depthEnable = testConf[`REG0_DEPTH_ENABLE];
    assign alphaFunc   = testConf[`REG0_ALPHA_FUNC_LSB +: `CMP_FUNC_WIDTH];
    assign alphaRef    = testConf[`REG0_ALPHA_REF_LSB +: `CHANNEL_WIDTH];
    assign texEnvMode  = shadeConf[`REG1_TEX_ENV_LSB +: `TEX_ENV_WIDTH];
    assign srcFactor   = shadeConf[`REG1_SRC_FACTOR_LSB +: `BLEND_FACTOR_WIDTH];
    assign dstFactor   = shadeConf[`REG1_DST_FACTOR_LSB +: `BLEND_FACTOR_WIDTH];

    ////////////////////////////////////////////////////////////
    // input, frame buffer read and depth test
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            s0Valid <= 1'b0;
            s1Valid <= 1'b0;
        end
        else
        begin
            s0Valid <= fragValid;
            s1Valid <= s0Valid;
        end
    end

    always_ff @(posedge clk)
    begin
        s0Index    <= fragIndex;
        s0Depth    <= fragDepth;
        s0TriColor <= fragColor;
        s0Texel    <= fragTexel;
        // read address doubles as the stage one index
        colorIndexRead <= s0Index;
        depthIndexRead <= s0Index;
        s1Depth    <= s0Depth;
        s1TriColor <= s0TriColor;
        s1Texel    <= s0Texel;
        s2Index    <= colorIndexRead;
        s2Depth    <= s1Depth;
        s2DepthIn  <= depthIn;
        s2DstColor <= colorIn;
        // dst color held one more cycle to meet the texenv result
        s3Index    <= s2Index;
        s3Depth    <= s2Depth;
        s3DstColor <= s2DstColor;
        s3DepthOk  <= depthPass || !depthEnable;
        s4Index    <= s3Index;
        s4Depth    <= s3Depth;
        s4Write    <= s3DepthOk && alphaPass;
        s5Index    <= s4Index;
        s5Depth    <= s4Depth;
        s5Write    <= s4Write;
    end

    compareFunc #(.VALUE_WIDTH(`DEPTH_WIDTH)) u_depthTest (
        .func      (depthFunc),
        .value     (s2Depth),
        .reference (s2DepthIn),
        .passed    (depthPass)
    );

    ////////////////////////////////////////////////////////////
    // shading
    ////////////////////////////////////////////////////////////
    texEnvUnit u_texEnvUnit (
        .clk      (clk),
        .rst      (rst),
        .mode     (texEnvMode),
        .triColor (s1TriColor),
        .texel    (s1Texel),
        .inValid  (s1Valid),
        .texColor (texColor),
        .outValid (texValid)
    );

    // alpha test on the texenv result
    compareFunc #(.VALUE_WIDTH(`CHANNEL_WIDTH)) u_alphaTest (
        .func      (alphaFunc),
        .value     (texColor[0 +: `CHANNEL_WIDTH]),
        .reference (alphaRef),
        .passed    (alphaPass)
    );

    blendUnit u_blendUnit (
        .clk        (clk),
        .rst        (rst),
        .srcFactor  (srcFactor),
        .dstFactor  (dstFactor),
        .srcColor   (texColor),
        .dstColor   (s3DstColor),
        .inValid    (texValid),
        .blendColor (blendColor),
        .outValid   (blendValid)
    );

    ////////////////////////////////////////////////////////////
    // write back and in-flight count
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            colorWriteEnable <= 1'b0;
            depthWriteEnable <= 1'b0;
        end
        else
        begin
            colorWriteEnable <= blendValid && s5Write;
            depthWriteEnable <= blendValid && s5Write && depthEnable;
        end
    end

    always_ff @(posedge clk)
    begin
        colorIndexWrite <= s5Index;
        depthIndexWrite <= s5Index;
        colorOut        <= blendColor;
        depthOut        <= s5Depth;
    end

    // at most six fragments between acceptance and write back
    always_ff @(posedge clk)
    begin
        if (rst)
            inFlight <= '0;
        else if (fragValid && !blendValid)
            inFlight <= inFlight + 3'd1;
        else if (!fragValid && blendValid)
            inFlight <= inFlight - 3'd1;
    end

    assign fragBusy = inFlight != '0;

endmodule

// File: design/fragmentPkg.sv
/*
 * fragment pipeline types
 * vector types shared by the pipeline blocks, plus the channel saturation rule
 */
`include "fragmentParams.svh"

package fragmentPkg;

    typedef logic [`FB_INDEX_WIDTH-1:0]        fbIndexT;
    typedef logic [`DEPTH_WIDTH-1:0]           depthT;
    typedef logic [`CHANNEL_WIDTH-1:0]         channelT;
    // rgba4444, red in the top nibble, alpha in the low nibble
    typedef logic [4*`CHANNEL_WIDTH-1:0]       colorT;
    typedef logic [2*`CHANNEL_WIDTH-1:0]       productT;
    typedef logic [`CONF_DATA_WIDTH-1:0]       confWordT;
    typedef logic [`CMP_FUNC_WIDTH-1:0]        cmpFuncT;
    typedef logic [`TEX_ENV_WIDTH-1:0]         texEnvFuncT;
    typedef logic [`BLEND_FACTOR_WIDTH-1:0]    blendFactorT;

    // a*b + c*d + 15, then keep the upper nibble or clamp on carry
    function automatic channelT saturateSum(productT p0, productT p1);
        logic [2*`CHANNEL_WIDTH:0] sum;
        sum = {1'b0, p0} + {1'b0, p1} + (2*`CHANNEL_WIDTH+1)'(`CHANNEL_MAX);
        return sum[2*`CHANNEL_WIDTH] ? `CHANNEL_MAX
                                     : sum[2*`CHANNEL_WIDTH-1 -: `CHANNEL_WIDTH];
    endfunction

endpackage

// File: design/texEnvUnit.sv
/*
 * texture environment combiner
 * mixes texel and triangle color per channel, two stages deep
 */
`timescale 1ns/1ps
`include "fragmentParams.svh"

module texEnvUnit
    import fragmentPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  texEnvFuncT mode,
    input  colorT      triColor,
    input  colorT      texel,
    input  logic       inValid,
    output colorT      texColor,
    output logic       outValid
);

    localparam int CHANNELS = $bits(colorT) / `CHANNEL_WIDTH;

    channelT opA [CHANNELS];
    channelT opB [CHANNELS];
    channelT opC [CHANNELS];
    channelT opD [CHANNELS];
    productT prodAB [CHANNELS];
    productT prodCD [CHANNELS];
    logic    prodValid;

    ////////////////////////////////////////////////////////////
    // operand select, result is a*b + c*d
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        channelT triCh;
        channelT texCh;
        channelT texAlpha;
        texAlpha = texel[0 +: `CHANNEL_WIDTH];
        // channel 0 is alpha
        for (int c = 0; c < CHANNELS; c++)
        begin
            triCh = triColor[c*`CHANNEL_WIDTH +: `CHANNEL_WIDTH];
            texCh = texel[c*`CHANNEL_WIDTH +: `CHANNEL_WIDTH];
            opA[c] = triCh;
            opB[c] = `CHANNEL_MAX;
            opC[c] = '0;
            opD[c] = '0;
            case (mode)
                `TEX_ENV_REPLACE:
                    opA[c] = texCh;
                `TEX_ENV_MODULATE:
                    opB[c] = texCh;
                `TEX_ENV_DECAL:
                begin
                    // alpha keeps the triangle value
                    if (c != 0)
                    begin
                        opB[c] = `CHANNEL_MAX - texAlpha;
                        opC[c] = texCh;
                        opD[c] = texAlpha;
                    end
                end
                default:
                    opA[c] = triCh;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // stage one products, stage two sum
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        for (int c = 0; c < CHANNELS; c++)
        begin
            prodAB[c] <= productT'(opA[c]) * productT'(opB[c]);
            prodCD[c] <= productT'(opC[c]) * productT'(opD[c]);
        end
    end

    always_ff @(posedge clk)
    begin
        for (int c = 0; c < CHANNELS; c++)
            texColor[c*`CHANNEL_WIDTH +: `CHANNEL_WIDTH] <= saturateSum(prodAB[c], prodCD[c]);
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            prodValid <= 1'b0;
            outValid  <= 1'b0;
        end
        else
        begin
            prodValid <= inValid;
            outValid  <= prodValid;
        end
    end

endmodule

// File: files.f
+incdir+design
design/fragmentPkg.sv
design/confRegs.sv
design/compareFunc.sv
design/texEnvUnit.sv
design/blendUnit.sv
design/fragmentPipeline.sv
verif/fragmentPipelineTb.sv

// File: verif/fragmentPipelineTb.sv
/*
 * fragment pipeline testbench
 * frame buffer model, wishbone driver, reference model and directed tests
 */
`timescale 1ns/1ps
`include "fragmentParams.svh"

module fragmentPipelineTb
    import fragmentPkg::*;
();

    localparam int PASS_FRAGS  = 8;
    localparam int MODE_FRAGS  = 8;
    localparam int DEPTH_FRAGS = 16;
    localparam int BLEND_FRAGS = 16;
    localparam int BURST_FRAGS = 20;
    localparam int TOTAL_FRAGS = PASS_FRAGS + 3 * MODE_FRAGS + 3 * DEPTH_FRAGS
                               + 3 * BLEND_FRAGS + BURST_FRAGS;
    localparam int FB_SIZE     = 1 << `FB_INDEX_WIDTH;

    logic                        clk;
    logic                        rst;
    logic                        wbCyc;
    logic                        wbStb;
    logic                        wbWe;
    logic [`CONF_ADDR_WIDTH-1:0] wbAdr;
    confWordT                    wbDatW;
    logic                        wbAck;
    confWordT                    wbDatR;
    logic                        fragValid;
    fbIndexT                     fragIndex;
    depthT                       fragDepth;
    colorT                       fragColor;
    colorT                       fragTexel;
    fbIndexT                     colorIndexRead;
    fbIndexT                     depthIndexRead;
    colorT                       colorIn;
    depthT                       depthIn;
    fbIndexT                     colorIndexWrite;
    fbIndexT                     depthIndexWrite;
    logic                        colorWriteEnable;
    logic                        depthWriteEnable;
    colorT                       colorOut;
    depthT                       depthOut;
    logic                        fragBusy;

    colorT    colorMem [FB_SIZE];
    depthT    depthMem [FB_SIZE];
    integer   seed = 32'h439f0e33;
    fbIndexT  nextIndex = 14'h0100;
    confWordT curTest = '0;
    confWordT curShade = '0;
    fbIndexT  expIndex [$];
    colorT    expColor [$];
    depthT    expDepth [$];

    fragmentPipeline u_fragmentPipeline (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // frame buffer model with read data following the registered address
    assign colorIn = colorMem[colorIndexRead];
    assign depthIn = depthMem[depthIndexRead];

    always @(posedge clk)
    begin
        if (colorWriteEnable)
            colorMem[colorIndexWrite] <= colorOut;
        if (depthWriteEnable)
            depthMem[depthIndexWrite] <= depthOut;
    end

    initial
    begin
        repeat (200 * TOTAL_FRAGS + 2000) @(posedge clk);
        $display("timeout: the tests did not finish within the cycle budget");
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////
    task automatic failRun(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkColor(input string name, input colorT expected, input colorT actual);
        if (actual !== expected)
            failRun($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic checkDepth(input string name, input depthT expected, input depthT actual);
        if (actual !== expected)
            failRun($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic checkConf(input string name, input confWordT expected, input confWordT actual);
        if (actual !== expected)
            failRun($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////
    function automatic channelT satChan(int a, int b, int c, int d);
        int sum;
        sum = a * b + c * d + 15;
        return sum[8] ? 4'd15 : channelT'(sum[7:4]);
    endfunction

    function automatic bit cmpPass(cmpFuncT func, int value, int refValue);
        case (func)
            `CMP_NEVER:    return 1'b0;
            `CMP_LESS:     return value < refValue;
            `CMP_EQUAL:    return value == refValue;
            `CMP_LEQUAL:   return value <= refValue;
            `CMP_GREATER:  return value > refValue;
            `CMP_NOTEQUAL: return value != refValue;
            `CMP_GEQUAL:   return value >= refValue;
            default:       return 1'b1;
        endcase
    endfunction

    function automatic int weightOf(blendFactorT code, int as, int ad);
        case (code)
            `BLEND_ONE:                 return 15;
            `BLEND_SRC_ALPHA:           return as;
            `BLEND_ONE_MINUS_SRC_ALPHA: return 15 - as;
            `BLEND_DST_ALPHA:           return ad;
            `BLEND_ONE_MINUS_DST_ALPHA: return 15 - ad;
            default:                    return 0;
        endcase
    endfunction

    task automatic predict(input fbIndexT idx, input colorT triColor, input colorT tex,
                           input depthT d, output colorT expC, output depthT expD);
        colorT      texC;
        colorT      blendC;
        colorT      dst;
        texEnvFuncT mode;
        logic       depthEn;
        bit         writable;
        int         t;
        int         x;
        int         ta;
        int         ws;
        int         wd;
        dst     = colorMem[idx];
        mode    = curShade[`REG1_TEX_ENV_LSB +: `TEX_ENV_WIDTH];
        depthEn = curTest[`REG0_DEPTH_ENABLE];
        ta      = tex[3:0];
        // channel 0 is alpha and channel 3 is red
        for (int i = 0; i < 4; i++)
        begin
            t = triColor[i*4 +: 4];
            x = tex[i*4 +: 4];
            case (mode)
                `TEX_ENV_REPLACE:  texC[i*4 +: 4] = satChan(x, 15, 0, 0);
                `TEX_ENV_MODULATE: texC[i*4 +: 4] = satChan(t, x, 0, 0);
                `TEX_ENV_DECAL:
                    texC[i*4 +: 4] = (i == 0) ? satChan(t, 15, 0, 0)
                                              : satChan(t, 15 - ta, x, ta);
                default:           texC[i*4 +: 4] = satChan(t, 15, 0, 0);
            endcase
        end
        ws = weightOf(curShade[`REG1_SRC_FACTOR_LSB +: 3], texC[3:0], dst[3:0]);
        wd = weightOf(curShade[`REG1_DST_FACTOR_LSB +: 3], texC[3:0], dst[3:0]);
        for (int i = 0; i < 4; i++)
            blendC[i*4 +: 4] = satChan(ws, texC[i*4 +: 4], wd, dst[i*4 +: 4]);
        writable = cmpPass(curTest[`REG0_ALPHA_FUNC_LSB +: 3], texC[3:0],
                           curTest[`REG0_ALPHA_REF_LSB +: 4])
                && (!depthEn || cmpPass(curTest[`REG0_DEPTH_FUNC_LSB +: 3], d, depthMem[idx]));
        expC = writable ? blendC : dst;
        expD = (writable && depthEn) ? d : depthMem[idx];
    endtask

    ////////////////////////////////////////////////////////////
    // wishbone and fragment drivers
    ////////////////////////////////////////////////////////////
    task automatic wbAccess(input logic we, input logic [`CONF_ADDR_WIDTH-1:0] adr,
                            input confWordT dat, output confWordT rdat);
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        wbWe   = we;
        wbAdr  = adr;
        wbDatW = dat;
        @(posedge clk);
        #1;
        while (!wbAck)
        begin
            @(posedge clk);
            #1;
        end
        rdat  = wbDatR;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
    endtask

    function automatic confWordT testWord(logic en, cmpFuncT df, cmpFuncT af, channelT aref);
        confWordT w;
        w = '0;
        w[`REG0_DEPTH_FUNC_LSB +: 3] = df;
        w[`REG0_DEPTH_ENABLE]        = en;
        w[`REG0_ALPHA_FUNC_LSB +: 3] = af;
        w[`REG0_ALPHA_REF_LSB +: 4]  = aref;
        return w;
    endfunction

    function automatic confWordT shadeWord(texEnvFuncT m, blendFactorT s, blendFactorT d);
        confWordT w;
        w = '0;
        w[`REG1_TEX_ENV_LSB +: 2]    = m;
        w[`REG1_SRC_FACTOR_LSB +: 3] = s;
        w[`REG1_DST_FACTOR_LSB +: 3] = d;
        return w;
    endfunction

    task automatic configure(input confWordT tw, input confWordT sw);
        confWordT unused;
        wbAccess(1'b1, 1'b0, tw, unused);
        wbAccess(1'b1, 1'b1, sw, unused);
        curTest  = tw;
        curShade = sw;
    endtask

    task automatic sendFragment(input colorT triColor, input colorT tex, input depthT d);
        colorT expC;
        depthT expD;
        predict(nextIndex, triColor, tex, d, expC, expD);
        expIndex.push_back(nextIndex);
        expColor.push_back(expC);
        expDepth.push_back(expD);
        fragValid = 1'b1;
        fragIndex = nextIndex;
        fragDepth = d;
        fragColor = triColor;
        fragTexel = tex;
        // stride keeps every index of the run distinct
        nextIndex = nextIndex + fbIndexT'(37);
        @(posedge clk);
        #1;
    endtask

    task automatic sendRandom(input int count);
        for (int i = 0; i < count; i++)
            sendFragment(colorT'($random(seed)), colorT'($random(seed)),
                         depthT'($random(seed)));
    endtask

    task automatic drainAndCheck(input string name);
        fbIndexT idx;
        fragValid = 1'b0;
        if (!fragBusy)
            failRun($sformatf("%s: fragBusy is low with fragments in flight", name));
        while (fragBusy)
        begin
            @(posedge clk);
            #1;
        end
        // last write lands one edge after the count drops
        repeat (2) @(posedge clk);
        #1;
        while (expIndex.size() > 0)
        begin
            idx = expIndex.pop_front();
            checkColor($sformatf("%s color[%0d]", name, idx), expColor.pop_front(),
                       colorMem[idx]);
            checkDepth($sformatf("%s depth[%0d]", name, idx), expDepth.pop_front(),
                       depthMem[idx]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////
    task automatic testConfRegs();
        confWordT rd;
        confWordT w0;
        confWordT w1;
        wbAccess(1'b0, 1'b0, '0, rd);
        checkConf("conf reset reg0", '0, rd);
        wbAccess(1'b0, 1'b1, '0, rd);
        checkConf("conf reset reg1", shadeWord(`TEX_ENV_DISABLE, `BLEND_ONE, `BLEND_ZERO), rd);
        w0 = confWordT'($random(seed));
        w1 = confWordT'($random(seed));
        configure(w0, w1);
        wbAccess(1'b0, 1'b0, '0, rd);
        checkConf("conf readback reg0", w0, rd);
        wbAccess(1'b0, 1'b1, '0, rd);
        checkConf("conf readback reg1", w1, rd);
        configure('0, shadeWord(`TEX_ENV_DISABLE, `BLEND_ONE, `BLEND_ZERO));
    endtask

    task automatic testTexEnv();
        texEnvFuncT modes [3] = '{`TEX_ENV_REPLACE, `TEX_ENV_MODULATE, `TEX_ENV_DECAL};
        foreach (modes[m])
        begin
            configure('0, shadeWord(modes[m], `BLEND_ONE, `BLEND_ZERO));
            sendRandom(MODE_FRAGS);
            drainAndCheck($sformatf("texenv mode %0d", modes[m]));
        end
    endtask

    task automatic testDepth();
        cmpFuncT funcs [3] = '{`CMP_LESS, `CMP_GEQUAL, `CMP_NEVER};
        foreach (funcs[f])
        begin
            configure(testWord(1'b1, funcs[f], `CMP_ALWAYS, '0),
                      shadeWord(`TEX_ENV_MODULATE, `BLEND_ONE, `BLEND_ZERO));
            sendRandom(DEPTH_FRAGS);
            drainAndCheck($sformatf("depth func %0d", funcs[f]));
        end
    endtask

    task automatic testAlphaBlend();
        blendFactorT srcF [3] = '{`BLEND_SRC_ALPHA, `BLEND_DST_ALPHA, `BLEND_ZERO};
        blendFactorT dstF [3] = '{`BLEND_ONE_MINUS_SRC_ALPHA, `BLEND_ZERO, `BLEND_DST_ALPHA};
        foreach (srcF[k])
        begin
            configure(testWord(1'b0, `CMP_ALWAYS, `CMP_GREATER, channelT'($random(seed))),
                      shadeWord(`TEX_ENV_REPLACE, srcF[k], dstF[k]));
            sendRandom(BLEND_FRAGS);
            drainAndCheck($sformatf("blend src %0d dst %0d", srcF[k], dstF[k]));
        end
    endtask

    task automatic testThroughput();
        configure(testWord(1'b1, `CMP_LESS, `CMP_GEQUAL, channelT'($random(seed))),
                  shadeWord(`TEX_ENV_MODULATE, `BLEND_SRC_ALPHA, `BLEND_ONE_MINUS_SRC_ALPHA));
        sendRandom(1);
        if (!fragBusy)
            failRun("throughput: fragBusy did not rise after the first fragment");
        sendRandom(BURST_FRAGS - 1);
        drainAndCheck("throughput");
    endtask

    initial
    begin
        rst       = 1'b1;
        wbCyc     = 1'b0;
        wbStb     = 1'b0;
        wbWe      = 1'b0;
        wbAdr     = '0;
        wbDatW    = '0;
        fragValid = 1'b0;
        fragIndex = '0;
        fragDepth = '0;
        fragColor = '0;
        fragTexel = '0;
        for (int i = 0; i < FB_SIZE; i++)
        begin
            colorMem[i] <= colorT'((i * 40503) ^ (i >> 7));
            depthMem[i] <= depthT'((i * 52429) + (i >> 3) + 16'h1234);
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        testConfRegs();
        sendRandom(PASS_FRAGS);
        drainAndCheck("pass through");
        testTexEnv();
        testDepth();
        testAlphaBlend();
        testThroughput();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
